// File: memCtrl_params.svh
`ifndef MEMCTRL_PARAMS_SVH
`define MEMCTRL_PARAMS_SVH

// block geometry
`define BLOCK_BYTES_LOG 4
`define BLOCK_BYTES (1 << `BLOCK_BYTES_LOG)

// address and RAM port widths
`define ADDR_W 32
`define BYTE_W 8

// bytes in an uncached word
`define WORD_BYTES 4

// I/O space is marked by two address bits
`define IO_SEL_HI 17
`define IO_SEL_LO 16
`define IO_SEL_VAL 2'b11

`endif

// File: memCtrl_pkg.sv
`include "memCtrl_params.svh"

package memCtrl_pkg;

  typedef logic [`ADDR_W-1:0]                  byteAddr_t;
  typedef logic [`ADDR_W-`BLOCK_BYTES_LOG-1:0] blockAddr_t;  // address above block offset
  typedef logic [`BLOCK_BYTES*`BYTE_W-1:0]     block_t;
  typedef logic [`WORD_BYTES*`BYTE_W-1:0]      ioWord_t;
  typedef logic [`BYTE_W-1:0]                  byte_t;
  typedef logic [`BLOCK_BYTES_LOG-1:0]         beatIndex_t;
  typedef logic [`BLOCK_BYTES_LOG:0]           beatCount_t;  // 1 to 16 needs five bits

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } accessSize_t;

  typedef enum logic [1:0] {
    SRC_ICACHE = 2'd0,
    SRC_DCACHE = 2'd1,
    SRC_IO     = 2'd2
  } source_t;

  typedef struct packed {
    blockAddr_t addr;
    logic       write;  // 1 for writeback
    block_t     data;
  } cacheReq_t;

  typedef struct packed {
    byteAddr_t   addr;
    logic        write;
    accessSize_t size;
    ioWord_t     data;
  } ioReq_t;

  typedef struct packed {
    source_t    source;
    logic       write;
    byteAddr_t  addr;       // first byte of the burst
    beatCount_t beatCount;
    block_t     data;       // write bytes, beat 0 in the low byte
  } memCmd_t;

  typedef struct packed {
    source_t    source;
    beatIndex_t index;
    byte_t      data;
  } readBeat_t;

endpackage

// File: memArbiter.sv
`timescale 1ns/1ps
`include "memCtrl_params.svh"

module memArbiter
  import memCtrl_pkg::*;
(
  input  logic       clkIn,
  input  logic       resetIn,
  input  logic       icacheReq,
  input  blockAddr_t icacheAddr,
  input  logic       dcacheReq,
  input  cacheReq_t  dcacheReqData,
  input  logic       ioReq,
  input  ioReq_t     ioReqData,
  input  logic       busy,
  output logic       cmdValid,
  output memCmd_t    cmd
);

  logic       icachePend;
  logic       dcachePend;
  logic       ioPend;
  blockAddr_t icacheSlot;
  cacheReq_t  dcacheSlot;
  ioReq_t     ioSlot;
  memCmd_t    selCmd;
  memCmd_t    lastCmd;  // held so the burst sees a stable command

  function automatic beatCount_t sizeToBeats(accessSize_t size);
    case (size)
      SIZE_BYTE: return beatCount_t'(1);
      SIZE_HALF: return beatCount_t'(2);
      default:   return beatCount_t'(`WORD_BYTES);
    endcase
  endfunction

  // fixed priority: io, then dcache, then icache
  always_comb begin
    selCmd = lastCmd;
    if (ioPend) begin
      selCmd.source    = SRC_IO;
      selCmd.write     = ioSlot.write;
      selCmd.addr      = ioSlot.addr;
      selCmd.beatCount = sizeToBeats(ioSlot.size);
      selCmd.data      = block_t'(ioSlot.data);
    end else if (dcachePend) begin
      selCmd.source    = SRC_DCACHE;
      selCmd.write     = dcacheSlot.write;
      selCmd.addr      = {dcacheSlot.addr, {`BLOCK_BYTES_LOG{1'b0}}};
      selCmd.beatCount = beatCount_t'(`BLOCK_BYTES);
      selCmd.data      = dcacheSlot.data;
    end else if (icachePend) begin
      selCmd.source    = SRC_ICACHE;
      selCmd.write     = 1'b0;
      selCmd.addr      = {icacheSlot, {`BLOCK_BYTES_LOG{1'b0}}};
      selCmd.beatCount = beatCount_t'(`BLOCK_BYTES);
      selCmd.data      = '0;
    end
  end

  assign cmdValid = (ioPend || dcachePend || icachePend) && !busy;
  assign cmd      = cmdValid ? selCmd : lastCmd;

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      icachePend <= 1'b0;
      dcachePend <= 1'b0;
      ioPend     <= 1'b0;
    end else begin
      if (cmdValid) begin  // issued slot frees up
        case (selCmd.source)
          SRC_IO:     ioPend     <= 1'b0;
          SRC_DCACHE: dcachePend <= 1'b0;
          default:    icachePend <= 1'b0;
        endcase
      end
      if (icacheReq) icachePend <= 1'b1;
      if (dcacheReq) dcachePend <= 1'b1;
      if (ioReq)     ioPend     <= 1'b1;
    end
  end

  always_ff @(posedge clkIn) begin
    if (icacheReq) icacheSlot <= icacheAddr;
    if (dcacheReq) dcacheSlot <= dcacheReqData;
    if (ioReq)     ioSlot     <= ioReqData;
    if (cmdValid)  lastCmd    <= selCmd;
  end

endmodule

// File: burstSequencer.sv
`timescale 1ns/1ps
`include "memCtrl_params.svh"

module burstSequencer
  import memCtrl_pkg::*;
(
  input  logic      clkIn,
  input  logic      resetIn,
  input  logic      cmdValid,
  input  memCmd_t   cmd,
  input  byte_t     memIn,
  input  logic      ioBufferFull,
  output logic      busy,
  output byteAddr_t memAddr,
  output byte_t     memOut,
  output logic      memWrite,
  output logic      beatValid,
  output readBeat_t beat,
  output logic      writeDone,
  output source_t   writeDoneSource
);

  memCmd_t    cmdReg;
  logic       active;    // beats still to be driven
  beatIndex_t beatIdx;
  logic       readMark;  // a read byte is on memIn this cycle
  beatIndex_t readIdx;
  logic       stall;
  logic       lastBeat;

  // only I/O writes wait on the output buffer
  assign stall    = cmdReg.write && (cmdReg.source == SRC_IO) && ioBufferFull;
  assign lastBeat = ({1'b0, beatIdx} + beatCount_t'(1)) == cmdReg.beatCount;

  assign busy     = active || readMark;
  assign memWrite = active && cmdReg.write && !stall;
  assign memOut   = cmdReg.data[beatIdx*`BYTE_W +: `BYTE_W];  // low byte first

  // byte addressed last cycle comes back now
  assign beatValid = readMark;
  assign beat      = '{source: cmdReg.source, index: readIdx, data: memIn};

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      active    <= 1'b0;
      beatIdx   <= '0;
      readMark  <= 1'b0;
      readIdx   <= '0;
      memAddr   <= '0;
      writeDone <= 1'b0;
    end else begin
      writeDone <= 1'b0;
      readMark  <= active && !cmdReg.write;
      readIdx   <= beatIdx;
      if (cmdValid) begin
        active  <= 1'b1;
        beatIdx <= '0;
        memAddr <= cmd.addr;
      end else if (active && !stall) begin
        if (lastBeat) begin
          active    <= 1'b0;
          beatIdx   <= '0;
          memAddr   <= '0;  // park the bus while idle
          writeDone <= cmdReg.write;
        end else begin
          beatIdx <= beatIdx + beatIndex_t'(1);
          memAddr <= memAddr + byteAddr_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (cmdValid) cmdReg <= cmd;
    if (active && lastBeat) writeDoneSource <= cmdReg.source;
  end

endmodule

// File: beatPacker.sv
`timescale 1ns/1ps
`include "memCtrl_params.svh"

module beatPacker
  import memCtrl_pkg::*;
#(
  parameter type        payload_t   = block_t,
  parameter logic [3:0] SOURCE_MASK = 4'b0011  // one bit per source_t value
) (
  input  logic       clkIn,
  input  logic       resetIn,
  input  logic       beatValid,
  input  readBeat_t  beat,
  input  beatIndex_t lastIndex,
  output logic       done,
  output source_t    doneSource,
  output payload_t   payload
);

  localparam int NUM_BYTES = $bits(payload_t) / `BYTE_W;
  localparam int IDX_W     = $clog2(NUM_BYTES);

  logic             ownBeat;
  logic [IDX_W-1:0] slot;

  assign ownBeat = beatValid && SOURCE_MASK[beat.source];
  assign slot    = beat.index[IDX_W-1:0];

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      done <= 1'b0;
    end else begin
      done <= ownBeat && (beat.index == lastIndex);
    end
  end

  always_ff @(posedge clkIn) begin
    if (ownBeat) begin
      if (beat.index == '0) begin
        payload <= payload_t'(beat.data);  // first beat zero-fills the rest
      end else begin
        payload[slot*`BYTE_W +: `BYTE_W] <= beat.data;
      end
      doneSource <= beat.source;
    end
  end

endmodule

// File: memCtrl.sv
`timescale 1ns/1ps

module memCtrl
  import memCtrl_pkg::*;
(
  input  logic       clkIn,
  input  logic       resetIn,
  input  logic       icacheReq,
  input  blockAddr_t icacheAddr,
  input  logic       dcacheReq,
  input  cacheReq_t  dcacheReqData,
  input  logic       ioReq,
  input  ioReq_t     ioReqData,
  input  logic       ioBufferFull,
  input  byte_t      memIn,
  output byteAddr_t  memAddr,
  output byte_t      memOut,
  output logic       memWrite,
  output logic       icacheFill,
  output logic       dcacheFill,
  output block_t     fillData,
  output logic       dcacheWriteDone,
  output logic       ioReadDone,
  output ioWord_t    ioReadData,
  output logic       ioWriteDone
);

  localparam logic [3:0] BLOCK_SOURCES = (4'd1 << SRC_ICACHE) | (4'd1 << SRC_DCACHE);
  localparam logic [3:0] WORD_SOURCES  = 4'd1 << SRC_IO;

  logic       cmdValid;
  memCmd_t    cmd;
  logic       busy;
  logic       beatValid;
  readBeat_t  beat;
  logic       writeDone;
  source_t    writeDoneSource;
  logic       blockDone;
  source_t    blockSource;
  logic       wordDone;
  beatIndex_t lastIndex;

  // cmd holds the issued command for the whole burst
  assign lastIndex = beatIndex_t'(cmd.beatCount - beatCount_t'(1));

  memArbiter arbiter (
    .clkIn         (clkIn),
    .resetIn       (resetIn),
    .icacheReq     (icacheReq),
    .icacheAddr    (icacheAddr),
    .dcacheReq     (dcacheReq),
    .dcacheReqData (dcacheReqData),
    .ioReq         (ioReq),
    .ioReqData     (ioReqData),
    .busy          (busy),
    .cmdValid      (cmdValid),
    .cmd           (cmd)
  );

  burstSequencer sequencer (
    .clkIn           (clkIn),
    .resetIn         (resetIn),
    .cmdValid        (cmdValid),
    .cmd             (cmd),
    .memIn           (memIn),
    .ioBufferFull    (ioBufferFull),
    .busy            (busy),
    .memAddr         (memAddr),
    .memOut          (memOut),
    .memWrite        (memWrite),
    .beatValid       (beatValid),
    .beat            (beat),
    .writeDone       (writeDone),
    .writeDoneSource (writeDoneSource)
  );

  beatPacker #(
    .payload_t   (block_t),
    .SOURCE_MASK (BLOCK_SOURCES)
  ) blockPacker (
    .clkIn      (clkIn),
    .resetIn    (resetIn),
    .beatValid  (beatValid),
    .beat       (beat),
    .lastIndex  (lastIndex),
    .done       (blockDone),
    .doneSource (blockSource),
    .payload    (fillData)
  );

  beatPacker #(
    .payload_t   (ioWord_t),
    .SOURCE_MASK (WORD_SOURCES)
  ) wordPacker (
    .clkIn      (clkIn),
    .resetIn    (resetIn),
    .beatValid  (beatValid),
    .beat       (beat),
    .lastIndex  (lastIndex),
    .done       (wordDone),
    .doneSource (),
    .payload    (ioReadData)
  );

  // route the strobes back to the requester
  assign icacheFill      = blockDone && (blockSource == SRC_ICACHE);
  assign dcacheFill      = blockDone && (blockSource == SRC_DCACHE);
  assign ioReadDone      = wordDone;  // word packer only takes io beats
  assign dcacheWriteDone = writeDone && (writeDoneSource == SRC_DCACHE);
  assign ioWriteDone     = writeDone && (writeDoneSource == SRC_IO);

endmodule

// File: memCtrl_assertions.sv
`timescale 1ns/1ps
`include "memCtrl_params.svh"

module memCtrlAssertions
  import memCtrl_pkg::*;
(
  input logic       clkIn,
  input logic       resetIn,
  input logic       cmdValid,
  input logic       busy,
  input logic       memWrite,
  input byteAddr_t  memAddr,
  input logic       ioBufferFull,
  input logic [4:0] strobes  // all response strobes
);

  logic ioBeat;

  assign ioBeat = memWrite && (memAddr[`IO_SEL_HI:`IO_SEL_LO] == `IO_SEL_VAL);

  // busy must cover the burst so no second command overlaps it
  busyAfterCmd: assert property (@(posedge clkIn) disable iff (resetIn)
    cmdValid |=> busy)
    else $error("sequencer was not busy in the cycle after a command");

  idleBusParked: assert property (@(posedge clkIn) disable iff (resetIn)
    !busy |-> (memAddr == '0 && !memWrite))
    else $error("RAM address or write enable active with the sequencer idle");

  noIoWriteWhenFull: assert property (@(posedge clkIn) disable iff (resetIn)
    !(ioBeat && ioBufferFull))
    else $error("I/O write beat issued while the I/O buffer was full");

  // no strobe high two cycles running
  strobesSingleCycle: assert property (@(posedge clkIn) disable iff (resetIn)
    (strobes & $past(strobes)) == '0)
    else $error("a response strobe stayed high for more than one cycle");

endmodule

bind memCtrl memCtrlAssertions protocolChecks (
  .clkIn        (clkIn),
  .resetIn      (resetIn),
  .cmdValid     (cmdValid),
  .busy         (busy),
  .memWrite     (memWrite),
  .memAddr      (memAddr),
  .ioBufferFull (ioBufferFull),
  .strobes      ({icacheFill, dcacheFill, dcacheWriteDone, ioReadDone, ioWriteDone})
);

// File: memCtrl_tb.sv
`timescale 1ns/1ps
`include "memCtrl_params.svh"

module memCtrl_tb
  import memCtrl_pkg::*;
();

  localparam int WAIT_LIMIT = 200;  // cycles per response wait
  localparam int IO_STALL   = 6;    // buffer-full cycles on each I/O write
  localparam int IC_FILL    = 0;
  localparam int DC_FILL    = 1;
  localparam int DC_WDONE   = 2;
  localparam int IO_RDONE   = 3;
  localparam int IO_WDONE   = 4;

  typedef struct packed {
    logic [2:0]   kind;
    logic [127:0] data;
    logic [31:0]  cycle;
  } resp_t;

  logic       clkIn;
  logic       resetIn;
  logic       icacheReq;
  logic       dcacheReq;
  logic       ioReq;
  logic       ioBufferFull;
  blockAddr_t icacheAddr;
  cacheReq_t  dcacheReqData;
  ioReq_t     ioReqData;
  byte_t      memIn;
  byteAddr_t  memAddr;
  byte_t      memOut;
  logic       memWrite;
  logic       icacheFill;
  logic       dcacheFill;
  logic       dcacheWriteDone;
  logic       ioReadDone;
  logic       ioWriteDone;
  block_t     fillData;
  ioWord_t    ioReadData;

  byte_t  ram [0:(1 << 17) - 1];  // 128 KiB, I/O reads alias into it
  byte_t  ioLog[$];
  resp_t  respQ[$];
  integer seed;
  int     cycleNow;
  int     errors;
  int     testsRun;
  int     testsFailed;

  memCtrl memCtrl_inst (.*);

  initial begin
    clkIn = 1'b0;
    forever #4 clkIn = ~clkIn;
  end

  // RAM model, one cycle read latency, I/O writes go to the log
  initial begin
    seed  = 32'hb0d7;
    memIn = '0;
    for (int i = 0; i < (1 << 17); i++) begin
      ram[i] = byte_t'($random(seed));
    end
    forever begin
      @(posedge clkIn);
      memIn <= ram[memAddr[16:0]];
      if (memWrite && memAddr[`IO_SEL_HI:`IO_SEL_LO] == `IO_SEL_VAL) begin
        ioLog.push_back(memOut);
      end else if (memWrite) begin
        ram[memAddr[16:0]] <= memOut;
      end
    end
  end

  task automatic logResp(int kind, logic [127:0] data);
    resp_t r;
    r.kind  = 3'(kind);
    r.data  = data;
    r.cycle = 32'(cycleNow);
    respQ.push_back(r);
  endtask

  // strobes sampled at the edge that closes their cycle
  always @(posedge clkIn) begin
    if (icacheFill) logResp(IC_FILL, fillData);
    if (dcacheFill) logResp(DC_FILL, fillData);
    if (dcacheWriteDone) logResp(DC_WDONE, '0);
    if (ioReadDone) logResp(IO_RDONE, 128'(ioReadData));
    if (ioWriteDone) logResp(IO_WDONE, '0);
    cycleNow++;
  end

  function automatic logic [127:0] modelBytes(logic [31:0] addr, int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = ram[17'(addr + 32'(i))];  // little endian
    end
    return v;
  endfunction

  function automatic logic [127:0] lowBytes(logic [127:0] data, int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = data[i*8 +: 8];
    end
    return v;
  endfunction

  function automatic int beatsFor(string size);
    if (size == "b") return 1;
    if (size == "h") return 2;
    if (size == "w") return 4;
    return `BLOCK_BYTES;
  endfunction

  function automatic int kindFor(string src, string op);
    if (src == "ic") return IC_FILL;
    if (src == "dc") return (op == "w") ? DC_WDONE : DC_FILL;
    return (op == "w") ? IO_WDONE : IO_RDONE;
  endfunction

  task automatic checkValue(string name, string what, logic [127:0] expVal,
                            logic [127:0] actVal);
    assert (actVal === expVal) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", name, what, expVal, actVal);
      errors++;
    end
  endtask

  task automatic waitResponses(int want, int stallCycles, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < WAIT_LIMIT) begin
      @(negedge clkIn);
      cycles++;
      if (cycles == stallCycles) ioBufferFull = 1'b0;  // buffer drains
      ok = (respQ.size() >= want);
    end
    ioBufferFull = 1'b0;
  endtask

  task automatic runCase(string name, string src, string op, string size,
                         logic [31:0] addr, logic [127:0] wdata, string expStr);
    int           nBeats;
    int           failsBefore;
    int           want;
    int           reqCycle;
    bit           ok;
    logic [31:0]  base;
    logic [31:0]  ioAddr;
    logic [127:0] expVal;
    logic [127:0] got;
    nBeats      = beatsFor(size);
    failsBefore = errors;
    want        = (src == "all") ? 3 : 1;
    base        = (nBeats == `BLOCK_BYTES) ? {addr[31:4], 4'h0} : addr;
    ioAddr      = (src == "all") ? (addr | 32'h0003_0000) : addr;
    respQ.delete();
    ioLog.delete();
    @(negedge clkIn);
    reqCycle = cycleNow;
    if (src == "ic" || src == "all") begin
      icacheReq  = 1'b1;
      icacheAddr = addr[31:4];
    end
    if (src == "dc" || src == "all") begin
      dcacheReq           = 1'b1;
      dcacheReqData.addr  = (src == "all") ? addr[31:4] + 28'd1 : addr[31:4];
      dcacheReqData.write = (op == "w");
      dcacheReqData.data  = wdata;
    end
    if (src == "io" || src == "all") begin
      ioReq           = 1'b1;
      ioReqData.addr  = ioAddr;
      ioReqData.write = (op == "w");
      ioReqData.size  = (nBeats == 1) ? SIZE_BYTE : (nBeats == 2) ? SIZE_HALF : SIZE_WORD;
      ioReqData.data  = wdata[31:0];
      ioBufferFull    = (op == "w");  // write starts against a full buffer
    end
    @(negedge clkIn);
    icacheReq = 1'b0;
    dcacheReq = 1'b0;
    ioReq     = 1'b0;
    waitResponses(want, (src == "io" && op == "w") ? IO_STALL : 0, ok);
    assert (ok) else begin
      $display("test %s timed out with %0d of %0d responses", name, respQ.size(), want);
      errors++;
    end
    if (ok && src == "all") begin
      checkValue(name, "first kind", 128'(IO_RDONE), 128'(respQ[0].kind));
      checkValue(name, "io word", modelBytes(ioAddr, 4), respQ[0].data);
      checkValue(name, "second kind", 128'(DC_FILL), 128'(respQ[1].kind));
      checkValue(name, "dcache block", modelBytes(base + 32'd16, 16), respQ[1].data);
      checkValue(name, "third kind", 128'(IC_FILL), 128'(respQ[2].kind));
      checkValue(name, "icache block", modelBytes(base, 16), respQ[2].data);
    end else if (ok) begin
      checkValue(name, "kind", 128'(kindFor(src, op)), 128'(respQ[0].kind));
      if (op == "r") begin
        expVal = modelBytes(base, nBeats);
        if (expStr != "model") void'($sscanf(expStr, "%h", expVal));
        checkValue(name, "read data", expVal, respQ[0].data);
        checkValue(name, "latency", 128'(nBeats + 3), 128'(respQ[0].cycle - reqCycle));
      end else if (src == "dc") begin
        checkValue(name, "RAM block", wdata, modelBytes(base, 16));
        checkValue(name, "latency", 128'(nBeats + 2), 128'(respQ[0].cycle - reqCycle));
      end else begin
        got = '0;
        foreach (ioLog[i]) begin
          if (i < 16) got[i*8 +: 8] = ioLog[i];
        end
        checkValue(name, "I/O log size", 128'(nBeats), 128'(ioLog.size()));
        checkValue(name, "I/O log bytes", lowBytes(wdata, nBeats), got);
      end
    end
    testsRun++;
    if (errors == failsBefore) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s FAILED", name);
      testsFailed++;
    end
  endtask

  initial begin
    int           fd;
    string        line;
    string        name;
    string        src;
    string        op;
    string        size;
    string        expStr;
    logic [31:0]  addr;
    logic [127:0] wdata;
    resetIn       = 1'b1;
    icacheReq     = 1'b0;
    dcacheReq     = 1'b0;
    ioReq         = 1'b0;
    ioBufferFull  = 1'b0;
    icacheAddr    = '0;
    dcacheReqData = '0;
    ioReqData     = '0;
    cycleNow      = 0;
    errors        = 0;
    testsRun      = 0;
    testsFailed   = 0;
    repeat (16) @(negedge clkIn);
    resetIn = 1'b0;
    fd = $fopen("memCtrl_cases.txt", "r");
    assert (fd != 0) else begin
      $display("could not open the case file memCtrl_cases.txt");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.substr(0, 0) != "#" &&
          $sscanf(line, "%s %s %s %s %h %h %s", name, src, op, size, addr, wdata,
                  expStr) == 7) begin
        runCase(name, src, op, size, addr, wdata, expStr);
      end
    end
    if (fd != 0) $fclose(fd);
    $display("tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errors);
    if (errors == 0 && testsRun > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: memCtrl_cases.txt
# name source(ic/dc/io/all) op(r/w) size(b/h/w/blk) addr(hex) wdata(hex) expected(hex or model)
# all = icache at addr, dcache at the next block and an io word at addr|30000 in one cycle
icRefill     ic  r blk 00001230 0 model
dcWriteBack  dc  w blk 00002040 00112233445566778899aabbccddeeff model
dcRefill     dc  r blk 00002040 0 00112233445566778899aabbccddeeff
icRefillTop  ic  r blk 0001fff0 0 model
ioReadByte   io  r b   00030105 0 model
ioReadHalf   io  r h   0003020b 0 model
ioReadWord   io  r w   00030302 0 model
ioWriteByte  io  w b   00030010 a5 model
ioWriteHalf  io  w h   00030021 beef model
ioWriteWord  io  w w   00030030 cafef00d model
priority     all r blk 00004000 0 model
dcAfterPrio  dc  r blk 00004010 0 model

// File: memCtrl.f
+incdir+.
memCtrl_pkg.sv
memArbiter.sv
burstSequencer.sv
beatPacker.sv
memCtrl.sv
memCtrl_assertions.sv
memCtrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memCtrl_tb
FILELIST  ?= memCtrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) memCtrl_params.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM) memCtrl_cases.txt
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
